//--- design/spi_cmd_pkg.sv
`default_nettype none

package spi_cmd_pkg;

  // ----------------------------------------
  // Command word layout
  // ----------------------------------------

  localparam int ADDR_W = 3;
  localparam int DATA_W = 8;

  // One operation bit, then the address, then the write data
  localparam int CMD_W  = 1 + ADDR_W + DATA_W;
  localparam int OP_BIT = CMD_W - 1;

  // Operation carried in the top bit of the command
  typedef enum logic
  {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } cmd_op_e;

endpackage

`default_nettype wire

//--- design/spi_phy_pkg.sv
`default_nettype none

package spi_phy_pkg;

  // ----------------------------------------
  // Frame lengths on the bus
  // ----------------------------------------

  localparam int LEN_W = 4;

  localparam logic [LEN_W-1:0] HDR_BITS = 4'd4;
  localparam logic [LEN_W-1:0] RD_BITS  = 4'd8;

  // Sequencer states
  typedef enum logic [2:0]
  {
    ST_IDLE,
    ST_WRITE,
    ST_RD_HDR,
    ST_RD_GAP,
    ST_RD_DATA,
    ST_DONE
  } seq_state_e;

endpackage

`default_nettype wire

//--- design/spi_shift_if.sv
`timescale 1ns/1ns
`default_nettype none

interface spi_shift_if;

  // Frame request from the sequencer
  logic                             start;
  logic [spi_phy_pkg::LEN_W-1:0]    nbits;
  logic [spi_cmd_pkg::CMD_W-1:0]    tx_word;

  // Frame result from the shift engine
  logic                             done;
  logic [spi_cmd_pkg::DATA_W-1:0]   rx_byte;

  modport seq
  (
    output start,
    output nbits,
    output tx_word,
    input  done,
    input  rx_byte
  );

  modport eng
  (
    input  start,
    input  nbits,
    input  tx_word,
    output done,
    output rx_byte
  );

endinterface

`default_nettype wire

//--- design/spi_sclk_gen.sv
`timescale 1ns/1ns
`default_nettype none

module spi_sclk_gen #(
  parameter int SCLK_DIV = 5
) (
  input  logic clk,
  input  logic rst_n,
  input  logic en,
  output logic sclk,
  output logic rise,
  output logic fall
);

  // SCLK_DIV must be at least 2
  localparam int               CNT_W    = $clog2(SCLK_DIV);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(SCLK_DIV - 1);

  logic [CNT_W-1:0] cnt;
  logic             tick;

  // A tick marks the last clk of a half period, so sclk toggles on the next edge
  assign tick = en && (cnt == CNT_LAST);
  assign rise = tick && !sclk;
  assign fall = tick && sclk;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cnt  <= '0;
      sclk <= 1'b0;
    end
    else if (!en)
    begin
      cnt  <= '0;
      sclk <= 1'b0;
    end
    else if (tick)
    begin
      cnt  <= '0;
      sclk <= ~sclk;
    end
    else
    begin
      cnt <= cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- design/spi_shifter.sv
`timescale 1ns/1ns
`default_nettype none

module spi_shifter #(
  parameter int SCLK_DIV = 5
) (
  input  logic     clk,
  input  logic     rst_n,
  spi_shift_if.eng shift,
  output logic     sclk,
  output logic     cs_n,
  output logic     mosi,
  input  logic     miso
);

  localparam int CMD_W  = spi_cmd_pkg::CMD_W;
  localparam int DATA_W = spi_cmd_pkg::DATA_W;
  localparam int LEN_W  = spi_phy_pkg::LEN_W;

  localparam logic [LEN_W-1:0] LAST_BIT = LEN_W'(1);

  logic             busy;
  logic             rise;
  logic             fall;
  logic             last_fall;
  logic             done_q;
  logic [LEN_W-1:0] bits_left;
  logic [CMD_W-1:0] tx_sr;
  logic [DATA_W-1:0] rx_sr;

  // ----------------------------------------
  // Bit clock
  // ----------------------------------------

  spi_sclk_gen #(
    .SCLK_DIV (SCLK_DIV)
  ) u_sclk_gen (
    .clk   (clk),
    .rst_n (rst_n),
    .en    (busy),
    .sclk  (sclk),
    .rise  (rise),
    .fall  (fall)
  );

  assign last_fall = fall && (bits_left == LAST_BIT);

  // ----------------------------------------
  // Frame control
  // ----------------------------------------

  // The first bit goes out with cs_n, later bits follow each falling sclk
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy      <= 1'b0;
      cs_n      <= 1'b1;
      mosi      <= 1'b0;
      done_q    <= 1'b0;
      bits_left <= '0;
    end
    else
    begin
      done_q <= 1'b0;
      if (shift.start)
      begin
        busy      <= 1'b1;
        cs_n      <= 1'b0;
        mosi      <= shift.tx_word[CMD_W-1];
        bits_left <= shift.nbits;
      end
      else if (last_fall)
      begin
        busy      <= 1'b0;
        cs_n      <= 1'b1;
        mosi      <= 1'b0;
        done_q    <= 1'b1;
        bits_left <= '0;
      end
      else if (fall)
      begin
        mosi      <= tx_sr[CMD_W-1];
        bits_left <= bits_left - 1'b1;
      end
    end
  end

  // ----------------------------------------
  // Data shift registers
  // ----------------------------------------

  always_ff @(posedge clk)
  begin
    if (shift.start)
      tx_sr <= shift.tx_word << 1;
    else if (fall)
      tx_sr <= tx_sr << 1;

    // Sample miso in the clk just before sclk goes high
    if (rise)
      rx_sr <= {rx_sr[DATA_W-2:0], miso};
  end

  assign shift.done    = done_q;
  assign shift.rx_byte = rx_sr;

endmodule

`default_nettype wire

//--- design/spi_cmd_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module spi_cmd_ctrl #(
  parameter int GAP_CYCLES = 100
) (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic [spi_cmd_pkg::CMD_W-1:0]   cmd_in,
  input  logic                            cmd_vld,
  output logic                            cmd_rdy,
  output logic                            read_vld,
  output logic [spi_cmd_pkg::DATA_W-1:0]  read_data,
  spi_shift_if.seq                        shift
);

  localparam int CMD_W = spi_cmd_pkg::CMD_W;
  localparam int LEN_W = spi_phy_pkg::LEN_W;

  localparam logic [LEN_W-1:0] WR_BITS = LEN_W'(CMD_W);

  // GAP_CYCLES must be at least 3, the start register and the engine take
  // up the remaining two cycles of the gap
  localparam int               GAP_W    = $clog2(GAP_CYCLES);
  localparam logic [GAP_W-1:0] GAP_LAST = GAP_W'(GAP_CYCLES - 3);

  spi_phy_pkg::seq_state_e state;
  spi_cmd_pkg::cmd_op_e    in_op;

  logic             accept;
  logic             start_q;
  logic [CMD_W-1:0] cmd_reg;
  logic [GAP_W-1:0] gap_cnt;

  // ----------------------------------------
  // Intake
  // ----------------------------------------

  assign cmd_rdy  = (state == spi_phy_pkg::ST_IDLE) || (state == spi_phy_pkg::ST_DONE);
  assign read_vld = (state == spi_phy_pkg::ST_DONE);
  assign accept   = cmd_vld && cmd_rdy;
  assign in_op    = spi_cmd_pkg::cmd_op_e'(cmd_in[spi_cmd_pkg::OP_BIT]);

  always_ff @(posedge clk)
  begin
    if (accept)
      cmd_reg <= cmd_in;
  end

  // ----------------------------------------
  // Frame request
  // ----------------------------------------

  // The read header is the top four bits of the command, already left aligned
  always_comb
  begin
    case (state)
      spi_phy_pkg::ST_WRITE:
      begin
        shift.nbits   = WR_BITS;
        shift.tx_word = cmd_reg;
      end
      spi_phy_pkg::ST_RD_HDR:
      begin
        shift.nbits   = spi_phy_pkg::HDR_BITS;
        shift.tx_word = cmd_reg;
      end
      default:
      begin
        shift.nbits   = spi_phy_pkg::RD_BITS;
        shift.tx_word = '0;
      end
    endcase
  end

  assign shift.start = start_q;

  // ----------------------------------------
  // Sequencer FSM
  // ----------------------------------------

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state   <= spi_phy_pkg::ST_IDLE;
      start_q <= 1'b0;
      gap_cnt <= '0;
    end
    else
    begin
      start_q <= 1'b0;
      case (state)
        spi_phy_pkg::ST_IDLE,
        spi_phy_pkg::ST_DONE:
        begin
          if (accept)
          begin
            start_q <= 1'b1;
            state   <= (in_op == spi_cmd_pkg::OP_WRITE) ? spi_phy_pkg::ST_WRITE
                                                        : spi_phy_pkg::ST_RD_HDR;
          end
          else
          begin
            state <= spi_phy_pkg::ST_IDLE;
          end
        end
        spi_phy_pkg::ST_WRITE:
        begin
          if (shift.done)
            state <= spi_phy_pkg::ST_IDLE;
        end
        spi_phy_pkg::ST_RD_HDR:
        begin
          if (shift.done)
          begin
            state   <= spi_phy_pkg::ST_RD_GAP;
            gap_cnt <= '0;
          end
        end
        spi_phy_pkg::ST_RD_GAP:
        begin
          // cs_n went high with done and falls again one cycle after start
          if (gap_cnt == GAP_LAST)
          begin
            start_q <= 1'b1;
            state   <= spi_phy_pkg::ST_RD_DATA;
          end
          else
          begin
            gap_cnt <= gap_cnt + 1'b1;
          end
        end
        spi_phy_pkg::ST_RD_DATA:
        begin
          if (shift.done)
            state <= spi_phy_pkg::ST_DONE;
        end
        default:
        begin
          state <= spi_phy_pkg::ST_IDLE;
        end
      endcase
    end
  end

  // ----------------------------------------
  // Read result
  // ----------------------------------------

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      read_data <= '0;
    else if ((state == spi_phy_pkg::ST_RD_DATA) && shift.done)
      read_data <= shift.rx_byte;
  end

endmodule

`default_nettype wire

//--- design/spi_cmd_master.sv
`timescale 1ns/1ns
`default_nettype none

module spi_cmd_master #(
  parameter int SCLK_DIV   = 5,
  parameter int GAP_CYCLES = 100
) (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic [spi_cmd_pkg::CMD_W-1:0]   cmd_in,
  input  logic                            cmd_vld,
  output logic                            cmd_rdy,
  output logic                            sclk,
  output logic                            cs_n,
  output logic                            mosi,
  input  logic                            miso,
  output logic                            read_vld,
  output logic [spi_cmd_pkg::DATA_W-1:0]  read_data
);

  spi_shift_if shift_bus ();

  spi_cmd_ctrl #(
    .GAP_CYCLES (GAP_CYCLES)
  ) u_ctrl (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .read_vld  (read_vld),
    .read_data (read_data),
    .shift     (shift_bus.seq)
  );

  spi_shifter #(
    .SCLK_DIV (SCLK_DIV)
  ) u_shifter (
    .clk   (clk),
    .rst_n (rst_n),
    .shift (shift_bus.eng),
    .sclk  (sclk),
    .cs_n  (cs_n),
    .mosi  (mosi),
    .miso  (miso)
  );

endmodule

`default_nettype wire

//--- testbench/spi_slave_model.sv
`timescale 1ns/1ns
`default_nettype none

module spi_slave_model (
  input  logic        sclk,
  input  logic        cs_n,
  input  logic        mosi,
  output logic        miso,
  output logic [11:0] last_wr_frame,
  output int          last_bits,
  output int          frame_count
);

  logic [7:0]  regs [0:7];
  logic [11:0] rx_sr;
  logic [7:0]  tx_sr;
  logic [2:0]  rd_addr;
  logic        rd_pending = 1'b0;
  int          bit_cnt = 0;

  initial
  begin
    for (int i = 0; i < 8; i++)
      regs[i] = 8'h00;
    frame_count   = 0;
    last_bits     = 0;
    last_wr_frame = '0;
    miso          = 1'b0;
  end

  // ----------------------------------------
  // Receive side and frame decode
  // ----------------------------------------

  always @(posedge sclk or posedge cs_n)
  begin
    if (cs_n)
    begin
      frame_count <= frame_count + 1;
      last_bits   <= bit_cnt;
      bit_cnt     <= 0;
      if ((bit_cnt == spi_cmd_pkg::CMD_W) && rx_sr[spi_cmd_pkg::OP_BIT])
      begin
        regs[rx_sr[10:8]] <= rx_sr[7:0];
        last_wr_frame     <= rx_sr;
        rd_pending        <= 1'b0;
      end
      else if ((bit_cnt == spi_phy_pkg::HDR_BITS) && !rx_sr[3])
      begin
        // Header only, the data follows in the next frame
        rd_addr    <= rx_sr[2:0];
        rd_pending <= 1'b1;
      end
      else
        rd_pending <= 1'b0;
    end
    else
    begin
      rx_sr   <= {rx_sr[10:0], mosi};
      bit_cnt <= bit_cnt + 1;
    end
  end

  // First bit is ready when cs_n falls, the rest follow each falling sclk
  always @(negedge sclk or negedge cs_n)
  begin
    if (bit_cnt == 0)
    begin
      tx_sr <= rd_pending ? regs[rd_addr] : 8'h00;
      miso  <= rd_pending ? regs[rd_addr][7] : 1'b0;
    end
    else
    begin
      tx_sr <= tx_sr << 1;
      miso  <= tx_sr[6];
    end
  end

endmodule

`default_nettype wire

//--- testbench/tb_spi_cmd_master.sv
`timescale 1ns/1ns
`default_nettype none

module tb_spi_cmd_master;

  localparam int SCLK_DIV     = 3;
  localparam int GAP_CYCLES   = 20;
  localparam int RESET_CYCLES = 5;
  localparam int N_RANDOM     = 40;
  // 8 writes, 8 reads, one write with a busy poke and its read back
  localparam int N_CMDS       = 18 + N_RANDOM;
  localparam int CMD_BUDGET   = 24 * 2 * SCLK_DIV + GAP_CYCLES + 20;
  // Cycles for one whole write frame with margin for its start
  localparam int WR_FRAME     = (spi_cmd_pkg::CMD_W + 2) * 2 * SCLK_DIV;

  logic        clk;
  logic        rst_n;
  logic [11:0] cmd_in;
  logic        cmd_vld;
  logic        cmd_rdy;
  logic        sclk;
  logic        cs_n;
  logic        mosi;
  logic        miso;
  logic        read_vld;
  logic [7:0]  read_data;
  logic [11:0] last_wr_frame;
  int          last_bits;
  int          frame_count;

  logic [7:0]  ref_regs [0:7];
  logic [31:0] rng_state;
  int          rd_pulses = 0;
  int          cs_high_cnt = 0;
  int          last_gap = 0;

  spi_cmd_master #(
    .SCLK_DIV   (SCLK_DIV),
    .GAP_CYCLES (GAP_CYCLES)
  ) UUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .sclk      (sclk),
    .cs_n      (cs_n),
    .mosi      (mosi),
    .miso      (miso),
    .read_vld  (read_vld),
    .read_data (read_data)
  );

  spi_slave_model u_slave (
    .sclk          (sclk),
    .cs_n          (cs_n),
    .mosi          (mosi),
    .miso          (miso),
    .last_wr_frame (last_wr_frame),
    .last_bits     (last_bits),
    .frame_count   (frame_count)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic halt_run(input string msg);
    $display("%s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
    halt_run($sformatf("ERR %s got 0x%0h expected 0x%0h", name, got, exp));
  endtask

  function automatic logic [31:0] next_random(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // ----------------------------------------
  // Bus monitors and protocol checks
  // ----------------------------------------

  always @(posedge clk)
  begin
    if (read_vld)
      rd_pulses <= rd_pulses + 1;
    if (cs_n)
      cs_high_cnt <= cs_high_cnt + 1;
    else
    begin
      if (cs_high_cnt != 0)
        last_gap <= cs_high_cnt;
      cs_high_cnt <= 0;
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n) cs_n |-> !sclk)
    else halt_run("sclk was high while cs_n was high");
  assert property (@(posedge clk) disable iff (!rst_n) read_vld |=> !read_vld)
    else halt_run("read_vld stayed high for more than one cycle");
  assert property (@(posedge clk) disable iff (!rst_n) read_vld |-> cmd_rdy)
    else halt_run("read_vld was high while cmd_rdy was low");

  // ----------------------------------------
  // Command tasks start and end on a falling edge
  // ----------------------------------------

  task automatic issue(input logic [11:0] cmd);
    while (!cmd_rdy)
      @(negedge clk);
    cmd_in  = cmd;
    cmd_vld = 1'b1;
    @(negedge clk);
    cmd_vld = 1'b0;
  endtask

  task automatic write_reg(input logic [2:0] addr, input logic [7:0] data, input bit poke);
    logic [11:0] cmd;
    logic [2:0]  other;
    int          frames_before;
    cmd           = {spi_cmd_pkg::OP_WRITE, addr, data};
    other         = addr + 3'd1;
    frames_before = frame_count;
    issue(cmd);
    if (poke)
    begin
      // A second write aimed at the next address while the master is busy
      assert (!cmd_rdy) else mismatch("cmd_rdy", cmd_rdy, 1'b0);
      cmd_in  = {spi_cmd_pkg::OP_WRITE, other, ~data};
      cmd_vld = 1'b1;
      @(negedge clk);
      cmd_vld = 1'b0;
    end
    while (!cmd_rdy)
      @(negedge clk);
    ref_regs[addr] = data;
    repeat (poke ? WR_FRAME : 1) @(negedge clk);
    assert (frame_count == frames_before + 1)
      else mismatch("frame_count", frame_count, frames_before + 1);
    assert (last_bits == 12) else mismatch("sclk rises", last_bits, 12);
    assert (last_wr_frame == cmd) else mismatch("mosi frame", last_wr_frame, cmd);
    assert (u_slave.regs[other] == ref_regs[other])
      else mismatch("slave reg", u_slave.regs[other], ref_regs[other]);
  endtask

  task automatic read_reg(input logic [2:0] addr);
    int pulses_before;
    int frames_before;
    pulses_before = rd_pulses;
    frames_before = frame_count;
    issue({spi_cmd_pkg::OP_READ, addr, 8'h00});
    while (!cmd_rdy)
      @(negedge clk);
    assert (read_vld) else halt_run("cmd_rdy returned without a read_vld pulse");
    assert (read_data == ref_regs[addr]) else mismatch("read_data", read_data, ref_regs[addr]);
    @(negedge clk);
    assert (rd_pulses == pulses_before + 1)
      else mismatch("read_vld pulses", rd_pulses, pulses_before + 1);
    assert (frame_count == frames_before + 2)
      else mismatch("frame_count", frame_count, frames_before + 2);
    assert (last_gap >= GAP_CYCLES)
      else halt_run($sformatf("cs_n was high only %0d cycles between read frames", last_gap));
  endtask

  // ----------------------------------------
  // Main sequence and watchdog
  // ----------------------------------------

  initial
  begin
    logic [2:0] addr;
    cmd_in    = '0;
    cmd_vld   = 1'b0;
    rst_n     = 1'b0;
    rng_state = 32'h1255;
    for (int i = 0; i < 8; i++)
      ref_regs[i] = 8'h00;
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    assert (cmd_rdy == 1'b1) else mismatch("cmd_rdy", cmd_rdy, 1'b1);
    assert (cs_n == 1'b1) else mismatch("cs_n", cs_n, 1'b1);
    assert (sclk == 1'b0) else mismatch("sclk", sclk, 1'b0);
    assert (mosi == 1'b0) else mismatch("mosi", mosi, 1'b0);
    assert (read_vld == 1'b0) else mismatch("read_vld", read_vld, 1'b0);
    assert (read_data == 8'h00) else mismatch("read_data", read_data, 8'h00);

    for (int a = 0; a < 8; a++)
      write_reg(3'(a), 8'h3C ^ 8'(a * 37), 1'b0);
    for (int a = 7; a >= 0; a--)
      read_reg(3'(a));
    write_reg(3'd5, 8'hA7, 1'b1);
    read_reg(3'd5);

    for (int n = 0; n < N_RANDOM; n++)
    begin
      rng_state = next_random(rng_state);
      addr      = rng_state[10:8];
      if (rng_state[0])
        write_reg(addr, rng_state[23:16], 1'b0);
      else
        read_reg(addr);
    end
    $display("TEST RESULT: PASS");
    $finish;
  end

  initial
  begin
    repeat (RESET_CYCLES + 2 + N_CMDS * CMD_BUDGET) @(posedge clk);
    halt_run("timeout, the command sequence did not finish within its cycle budget");
  end

endmodule

`default_nettype wire

//--- spi_cmd.f
design/spi_cmd_pkg.sv
design/spi_phy_pkg.sv
design/spi_shift_if.sv
design/spi_sclk_gen.sv
design/spi_shifter.sv
design/spi_cmd_ctrl.sv
design/spi_cmd_master.sv
testbench/spi_slave_model.sv
testbench/tb_spi_cmd_master.sv

//--- Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_spi_cmd_master \
		-f spi_cmd.f -Mdir obj_dir -o sim_spi_cmd
	./obj_dir/sim_spi_cmd | tee $(LOG)
	@if grep -q "TEST RESULT: PASS" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
